//--- logic/hps_link_defines.svh
`ifndef HPS_LINK_DEFINES_SVH
`define HPS_LINK_DEFINES_SVH

// host command codes, first word of a frame
`define HPS_CMD_CFG        16'h0001
`define HPS_CMD_JOY0       16'h0002
`define HPS_CMD_JOY1       16'h0003
`define HPS_CMD_JOY2       16'h0010
`define HPS_CMD_JOY3       16'h0011
`define HPS_CMD_STATUS     16'h001e
`define HPS_CMD_STATUS_REQ 16'h0029
`define HPS_CMD_JOY_RAW    16'h000f
`define HPS_CMD_KBD        16'h0005
`define HPS_CMD_FILE_TX    16'h0053
`define HPS_CMD_FILE_DAT   16'h0054
`define HPS_CMD_FILE_INDEX 16'h0055
`define HPS_CMD_FILE_INFO  16'h0056

// number of joystick registers
`define HPS_JOY_COUNT      4

// upper nibble of the status request readback
`define HPS_REQ_MARK       4'ha
// high byte of a keyboard argument that skips the rest of the frame
`define HPS_SKIP_MARK      8'hff

`endif

//--- logic/hps_link_pkg.sv
`default_nettype none

package hps_link_pkg;

	// host side of the parallel link
	typedef struct packed {
		logic        enable;
		logic        strobe;
		logic [15:0] din;
	} host_bus_t;

	// one registered strobe, tagged with its frame command
	typedef struct packed {
		logic        valid;
		logic        first;
		logic [15:0] cmd;
		// argument number, 0 on the command word, saturates at 15
		logic [3:0]  index;
		logic [15:0] data;
	} frame_word_t;

	// byte-wide download stream
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [26:0] addr;
		logic [7:0]  dout;
		logic [31:0] file_ext;
	} ioctl_t;

	// key event, toggle flips once per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	typedef logic [31:0] joy_t;

endpackage

`default_nettype wire

//--- logic/frame_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module frame_decoder (
	input  wire logic                      clk_sys,
	input  wire logic                      reset,
	input  wire hps_link_pkg::host_bus_t   host,
	output hps_link_pkg::frame_word_t      word,
	output logic                           frame_end
);

	logic       has_cmd;
	logic [3:0] arg_cnt;
	logic       enable_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			word      <= '0;
			has_cmd   <= 1'b0;
			arg_cnt   <= 4'd1;
			enable_q  <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			enable_q   <= host.enable;
			frame_end  <= enable_q & ~host.enable;
			word.valid <= 1'b0;

			if (!host.enable) begin
				// idle between frames, next strobe is a command again
				has_cmd <= 1'b0;
				arg_cnt <= 4'd1;
			end else if (host.strobe) begin
				word.valid <= 1'b1;
				word.data  <= host.din;
				if (!has_cmd) begin
					word.first <= 1'b1;
					word.cmd   <= host.din;
					word.index <= 4'd0;
					has_cmd    <= 1'b1;
				end else begin
					// word.cmd keeps the command of this frame
					word.first <= 1'b0;
					word.index <= arg_cnt;
					if (arg_cnt != 4'hf)
						arg_cnt <= arg_cnt + 4'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/io_registers.sv
`timescale 1ns/100ps
`default_nettype none
`include "hps_link_defines.svh"

module io_registers (
	input  wire logic                                          clk_sys,
	input  wire logic                                          reset,
	input  wire hps_link_pkg::frame_word_t                     word,
	input  wire logic                                          frame_end,
	input  wire logic [15:0]                                   joy_raw,
	input  wire logic [63:0]                                   status_in,
	input  wire logic                                          status_set,
	output hps_link_pkg::joy_t [`HPS_JOY_COUNT-1:0]            joysticks,
	output logic [1:0]                                         buttons,
	output logic [63:0]                                        status,
	output logic [15:0]                                        host_dout
);

	logic                              joy_hit;
	logic [$clog2(`HPS_JOY_COUNT)-1:0] joy_sel;
	logic                              status_set_q;
	logic [3:0]                        req_count;
	logic [63:0]                       status_req;
	logic [15:0]                       rd_data;

	// joystick command to register number
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 2'd0;
		case (word.cmd)
			`HPS_CMD_JOY0: joy_sel = 2'd0;
			`HPS_CMD_JOY1: joy_sel = 2'd1;
			`HPS_CMD_JOY2: joy_sel = 2'd2;
			`HPS_CMD_JOY3: joy_sel = 2'd3;
			default:       joy_hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// read data for the slot being strobed
	always_comb begin
		rd_data = 16'h0000;
		if (word.first) begin
			if (word.cmd == `HPS_CMD_STATUS_REQ)
				rd_data = {8'h00, `HPS_REQ_MARK, req_count};
		end else begin
			case (word.cmd)
				`HPS_CMD_STATUS_REQ: begin
					case (word.index)
						4'd1:    rd_data = status_req[15:0];
						4'd2:    rd_data = status_req[31:16];
						4'd3:    rd_data = status_req[47:32];
						4'd4:    rd_data = status_req[63:48];
						default: rd_data = 16'h0000;
					endcase
				end
				`HPS_CMD_JOY_RAW: rd_data = joy_raw;
				default:          rd_data = 16'h0000;
			endcase
		end
	end

	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			joysticks    <= '0;
			buttons      <= 2'b00;
			status       <= 64'd0;
			status_set_q <= 1'b0;
			req_count    <= 4'd0;
			status_req   <= 64'd0;
			host_dout    <= 16'h0000;
		end else begin
			// status set request from the core, counted for the host
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				req_count  <= req_count + 4'd1;
				status_req <= status_in;
			end

			if (frame_end)
				host_dout <= 16'h0000;
			else if (word.valid)
				host_dout <= rd_data;

			if (word.valid && !word.first) begin
				if (joy_hit) begin
					// first argument is the low half, the rest the high half
					if (word.index == 4'd1)
						joysticks[joy_sel][15:0] <= word.data;
					else
						joysticks[joy_sel][31:16] <= word.data;
				end
				// only the two button bits of the config byte are kept
				if (word.cmd == `HPS_CMD_CFG)
					buttons <= word.data[1:0];
				if (word.cmd == `HPS_CMD_STATUS) begin
					case (word.index)
						4'd1:    status[15:0]  <= word.data;
						4'd2:    status[31:16] <= word.data;
						4'd3:    status[47:32] <= word.data;
						4'd4:    status[63:48] <= word.data;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/file_loader.sv
`timescale 1ns/100ps
`default_nettype none
`include "hps_link_defines.svh"

module file_loader (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire hps_link_pkg::frame_word_t word,
	output hps_link_pkg::ioctl_t       ioctl
);

	// next write address, also the byte count of the download
	logic [26:0] addr_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl  <= '0;
			addr_q <= 27'd0;
		end else begin
			ioctl.wr <= 1'b0;

			if (word.valid && !word.first) begin
				case (word.cmd)
					`HPS_CMD_FILE_INFO: begin
						// extension comes high half first
						if (word.index == 4'd1)
							ioctl.file_ext[31:16] <= word.data;
						else if (word.index == 4'd2)
							ioctl.file_ext[15:0] <= word.data;
					end

					`HPS_CMD_FILE_INDEX: ioctl.index <= word.data[7:0];

					`HPS_CMD_FILE_TX: begin
						if (word.data[7:0] != 8'h00) begin
							addr_q         <= 27'd0;
							ioctl.download <= 1'b1;
						end else begin
							// leave the final length visible on addr
							ioctl.addr     <= addr_q;
							ioctl.download <= 1'b0;
						end
					end

					`HPS_CMD_FILE_DAT: begin
						ioctl.addr <= addr_q;
						ioctl.dout <= word.data[7:0];
						ioctl.wr   <= 1'b1;
						addr_q     <= addr_q + 27'd1;
					end

					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/keyboard_decoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "hps_link_defines.svh"

module keyboard_decoder (
	input  wire logic                      clk_sys,
	input  wire logic                      reset,
	input  wire hps_link_pkg::frame_word_t word,
	input  wire logic                      frame_end,
	output hps_link_pkg::ps2_key_t         ps2_key
);

	logic        kbd_frame;
	logic        skip;
	logic [31:0] history;
	logic        pressed;
	logic        extended;

	// F0 before the code means release, E0 in front of that means extended
	assign pressed  = (history[15:8] != 8'hf0);
	assign extended = pressed ? (history[15:8] == 8'he0) : (history[23:16] == 8'he0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			kbd_frame <= 1'b0;
			skip      <= 1'b0;
			history   <= 32'd0;
			ps2_key   <= '0;
		end else begin
			if (frame_end) begin
				if (kbd_frame && !skip) begin
					ps2_key <= {~ps2_key.toggle, pressed, extended, history[7:0]};
					// print screen and pause have no single-code form
					case (history)
						32'he012e07c: ps2_key[9:0] <= 10'h37c;
						32'h7ce0f012: ps2_key[9:0] <= 10'h17c;
						32'hf014f077: ps2_key[9:0] <= 10'h377;
						default: ;
					endcase
				end
				kbd_frame <= 1'b0;
				skip      <= 1'b0;
			end else if (word.valid) begin
				if (word.first) begin
					kbd_frame <= (word.cmd == `HPS_CMD_KBD);
					skip      <= 1'b0;
					history   <= 32'd0;
				end else if (kbd_frame) begin
					if (word.data[15:8] == `HPS_SKIP_MARK)
						skip <= 1'b1;
					else if (!skip)
						history <= {history[23:0], word.data[7:0]};
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/hps_link.sv
`timescale 1ns/100ps
`default_nettype none
`include "hps_link_defines.svh"

module hps_link (
	input  wire logic                                   clk_sys,
	input  wire logic                                   reset,
	input  wire hps_link_pkg::host_bus_t                host,
	input  wire logic [15:0]                            joy_raw,
	input  wire logic [63:0]                            status_in,
	input  wire logic                                   status_set,
	input  wire logic                                   ioctl_wait,
	output logic [15:0]                                 host_dout,
	output logic                                        host_wait,
	output hps_link_pkg::joy_t [`HPS_JOY_COUNT-1:0]     joysticks,
	output logic [1:0]                                  buttons,
	output logic [63:0]                                 status,
	output hps_link_pkg::ioctl_t                        ioctl,
	output hps_link_pkg::ps2_key_t                      ps2_key
);

	hps_link_pkg::frame_word_t word;
	logic                      frame_end;

	// the host holds its next strobe while the download sink is busy
	assign host_wait = ioctl_wait;

	//////////////////////////////////////////////////
	frame_decoder u_frame (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.host      (host),
		.word      (word),
		.frame_end (frame_end)
	);

	io_registers u_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.word       (word),
		.frame_end  (frame_end),
		.joy_raw    (joy_raw),
		.status_in  (status_in),
		.status_set (status_set),
		.joysticks  (joysticks),
		.buttons    (buttons),
		.status     (status),
		.host_dout  (host_dout)
	);

	file_loader u_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.word    (word),
		.ioctl   (ioctl)
	);

	keyboard_decoder u_kbd (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.word      (word),
		.frame_end (frame_end),
		.ps2_key   (ps2_key)
	);

endmodule

`default_nettype wire

//--- tests/hps_link_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "hps_link_defines.svh"

module hps_link_checker (
	input  wire logic                                    clk_sys,
	input  wire logic                                    reset,
	input  wire hps_link_pkg::host_bus_t                 host,
	input  wire logic [15:0]                             joy_raw,
	input  wire logic [63:0]                             status_in,
	input  wire logic                                    status_set,
	input  wire logic [15:0]                             host_dout,
	input  wire logic                                    host_wait,
	input  wire logic                                    ioctl_wait,
	input  wire hps_link_pkg::joy_t [`HPS_JOY_COUNT-1:0] joysticks,
	input  wire logic [1:0]                              buttons,
	input  wire logic [63:0]                             status,
	input  wire hps_link_pkg::ioctl_t                    ioctl,
	input  wire hps_link_pkg::ps2_key_t                  ps2_key,
	input  wire logic [3:0]                              test_id,
	input  wire logic                                    test_done,
	input  wire logic                                    run_done,
	output int                                           error_count
);

	// model of the host side rebuilt from the snooped bus
	logic [15:0]            cmd = '0;
	logic                   in_frame = 1'b0;
	int                     arg_num = 0;
	logic                   enable_q = 1'b0;
	logic                   status_set_q = 1'b0;
	logic [3:0]             exp_req = '0;
	logic [63:0]            exp_capture = '0;
	hps_link_pkg::joy_t     exp_joy [`HPS_JOY_COUNT];
	logic [1:0]             exp_buttons = '0;
	logic [63:0]            exp_status = '0;
	logic                   exp_download = 1'b0;
	logic [7:0]             exp_index = '0;
	logic [31:0]            exp_ext = '0;
	logic [26:0]            exp_length = '0;
	logic                   length_check = 1'b0;
	logic [26:0]            wr_addr = '0;
	logic [7:0]             wr_bytes[$];
	logic [31:0]            kbd_hist = '0;
	logic                   kbd_skip = 1'b0;
	hps_link_pkg::ps2_key_t exp_key = '0;
	logic [15:0]            exp_rd = '0;
	logic                   rd_check = 1'b0;
	int                     rd_pend = 0;
	int                     end_pend = 0;
	int                     errors_before = 0;
	int                     tests_ok = 0;
	int                     tests_bad = 0;

	initial begin
		error_count = 0;
		foreach (exp_joy[i])
			exp_joy[i] = '0;
	end

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1:    return "joysticks and buttons";
			4'd2:    return "status write";
			4'd3:    return "status request and raw joystick readback";
			4'd4:    return "file download";
			default: return "keyboard events";
		endcase
	endfunction

	// key event by the scan code rules where the special sequences override the rest
	function automatic hps_link_pkg::ps2_key_t key_event(input logic [31:0] h, input logic tog);
		hps_link_pkg::ps2_key_t k;
		logic [7:0]             prefix;
		k.toggle  = tog;
		k.code    = h[7:0];
		k.pressed = (h[15:8] != 8'hf0);
		// byte in front of the code or in front of its F0 on a release
		prefix = h[15:8];
		if (!k.pressed)
			prefix = h[23:16];
		k.extended = (prefix == 8'he0);
		if (h == 32'he012e07c)
			k[9:0] = {1'b1, 1'b1, 8'h7c};
		else if (h == 32'h7ce0f012)
			k[9:0] = {1'b0, 1'b1, 8'h7c};
		else if (h == 32'hf014f077)
			k[9:0] = {1'b1, 1'b1, 8'h77};
		return k;
	endfunction

	function automatic logic [15:0] read_value();
		if (cmd == `HPS_CMD_STATUS_REQ) begin
			if (arg_num == 0)
				return {8'h00, `HPS_REQ_MARK, exp_req};
			if (arg_num >= 1 && arg_num <= 4)
				return exp_capture[16*(arg_num-1) +: 16];
			return 16'h0000;
		end
		if (cmd == `HPS_CMD_JOY_RAW && arg_num != 0)
			return joy_raw;
		return 16'h0000;
	endfunction

	task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic take_argument(input logic [15:0] data);
		case (cmd)
			`HPS_CMD_JOY0, `HPS_CMD_JOY1, `HPS_CMD_JOY2, `HPS_CMD_JOY3: begin
				int j;
				j = (cmd == `HPS_CMD_JOY0) ? 0 : (cmd == `HPS_CMD_JOY1) ? 1 :
					(cmd == `HPS_CMD_JOY2) ? 2 : 3;
				if (arg_num == 1)
					exp_joy[j][15:0] = data;
				else
					exp_joy[j][31:16] = data;
			end
			`HPS_CMD_CFG: exp_buttons = data[1:0];
			`HPS_CMD_STATUS: begin
				if (arg_num >= 1 && arg_num <= 4)
					exp_status[16*(arg_num-1) +: 16] = data;
			end
			`HPS_CMD_FILE_INDEX: exp_index = data[7:0];
			`HPS_CMD_FILE_INFO: begin
				if (arg_num == 1)
					exp_ext[31:16] = data;
				else if (arg_num == 2)
					exp_ext[15:0] = data;
			end
			`HPS_CMD_FILE_TX: begin
				if (data[7:0] != 8'h00) begin
					exp_download = 1'b1;
					exp_length   = '0;
					wr_addr      = '0;
				end else begin
					exp_download = 1'b0;
					length_check = 1'b1;
				end
			end
			`HPS_CMD_FILE_DAT: begin
				wr_bytes.push_back(data[7:0]);
				exp_length = exp_length + 27'd1;
			end
			`HPS_CMD_KBD: begin
				if (data[15:8] == `HPS_SKIP_MARK)
					kbd_skip = 1'b1;
				else if (!kbd_skip)
					kbd_hist = {kbd_hist[23:0], data[7:0]};
			end
			default: ;
		endcase
	endtask

	task automatic compare_outputs();
		for (int i = 0; i < `HPS_JOY_COUNT; i++)
			expect_eq(64'(joysticks[i]), 64'(exp_joy[i]), $sformatf("joystick %0d", i));
		expect_eq(64'(buttons), 64'(exp_buttons), "buttons");
		expect_eq(status, exp_status, "status");
		expect_eq(64'(ioctl.download), 64'(exp_download), "ioctl.download");
		expect_eq(64'(ioctl.index), 64'(exp_index), "ioctl.index");
		expect_eq(64'(ioctl.file_ext), 64'(exp_ext), "ioctl.file_ext");
		expect_eq(64'(ps2_key), 64'(exp_key), "ps2_key");
		expect_eq(64'(host_dout), 64'd0, "host_dout after the frame");
		if (length_check)
			expect_eq(64'(ioctl.addr), 64'(exp_length), "download length on ioctl.addr");
		length_check = 1'b0;
		if (wr_bytes.size() != 0) begin
			$display("%0d data bytes were sent but never written", wr_bytes.size());
			error_count++;
			wr_bytes.delete();
		end
	endtask

	//////////////////////////////////////////////////
	always @(posedge clk_sys) begin
		logic [7:0] byte_exp;
		if (!reset) begin
			// host_wait follows ioctl_wait within the same cycle
			expect_eq(64'(host_wait), 64'(ioctl_wait), "host_wait");

			if (status_set && !status_set_q) begin
				exp_req     = exp_req + 4'd1;
				exp_capture = status_in;
			end
			status_set_q = status_set;

			if (rd_pend == 1 && rd_check)
				expect_eq(64'(host_dout), 64'(exp_rd), $sformatf("read word %0d", arg_num));
			if (rd_pend != 0)
				rd_pend--;
			if (end_pend == 1)
				compare_outputs();
			if (end_pend != 0)
				end_pend--;

			if (ioctl.wr) begin
				if (wr_bytes.size() == 0) begin
					$display("Error at %0t: ioctl write with no data byte sent", $time);
					error_count++;
				end else begin
					byte_exp = wr_bytes.pop_front();
					expect_eq(64'(ioctl.addr), 64'(wr_addr), "ioctl.addr");
					expect_eq(64'(ioctl.dout), 64'(byte_exp), "ioctl.dout");
				end
				wr_addr = wr_addr + 27'd1;
			end

			if (host.enable && host.strobe) begin
				if (!in_frame) begin
					in_frame = 1'b1;
					cmd      = host.din;
					arg_num  = 0;
					kbd_skip = 1'b0;
					kbd_hist = '0;
				end else begin
					arg_num++;
					take_argument(host.din);
				end
				rd_check = (cmd == `HPS_CMD_STATUS_REQ) || (cmd == `HPS_CMD_JOY_RAW);
				exp_rd   = read_value();
				rd_pend  = 2;
			end

			// only an unskipped keyboard frame ends in a key event
			if (enable_q && !host.enable) begin
				if (in_frame && cmd == `HPS_CMD_KBD && !kbd_skip)
					exp_key = key_event(kbd_hist, ~exp_key.toggle);
				in_frame = 1'b0;
				end_pend = 2;
			end
			enable_q = host.enable;

			if (test_done) begin
				if (error_count == errors_before) begin
					tests_ok++;
					$display("test %0d %s: ok", test_id, test_name(test_id));
				end else begin
					tests_bad++;
					$display("test %0d %s: %0d errors", test_id, test_name(test_id),
						error_count - errors_before);
				end
				errors_before = error_count;
			end
			if (run_done)
				$display("%0d tests ok, %0d tests failed, %0d errors in all",
					tests_ok, tests_bad, error_count);
		end
	end

endmodule

`default_nettype wire

//--- tests/hps_link_assert.sv
`timescale 1ns/100ps
`default_nettype none

module hps_link_assert (
	input wire logic                    clk_sys,
	input wire logic                    reset,
	input wire hps_link_pkg::host_bus_t host,
	input wire hps_link_pkg::ioctl_t    ioctl,
	input wire hps_link_pkg::ps2_key_t  ps2_key
);

	wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl.wr |=> !ioctl.wr)
		else $error("ioctl.wr high for more than one cycle");

	// a key event lands two cycles after enable falls
	key_after_end: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(ps2_key) |-> $past(host.enable, 3) && !$past(host.enable, 2))
		else $error("ps2_key changed other than two cycles after enable fell");

endmodule

bind hps_link hps_link_assert assert0 (
	.clk_sys (clk_sys),
	.reset   (reset),
	.host    (host),
	.ioctl   (ioctl),
	.ps2_key (ps2_key)
);

`default_nettype wire

//--- tests/hps_link_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "hps_link_defines.svh"

module hps_link_tb;

	logic                                    clk_sys;
	logic                                    reset;
	hps_link_pkg::host_bus_t                 host;
	logic [15:0]                             joy_raw;
	logic [63:0]                             status_in;
	logic                                    status_set;
	logic                                    ioctl_wait = 1'b0;
	logic                                    wait_random;
	logic [15:0]                             host_dout;
	logic                                    host_wait;
	hps_link_pkg::joy_t [`HPS_JOY_COUNT-1:0] joysticks;
	logic [1:0]                              buttons;
	logic [63:0]                             status;
	hps_link_pkg::ioctl_t                    ioctl;
	hps_link_pkg::ps2_key_t                  ps2_key;
	logic [3:0]                              test_id;
	logic                                    test_done;
	logic                                    run_done;
	int                                      error_count;
	logic [15:0]                             args[$];

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	// download sink busy at random while a download test runs
	always @(posedge clk_sys) begin
		if (wait_random)
			ioctl_wait <= ($urandom % 3 == 0);
		else
			ioctl_wait <= 1'b0;
	end

	hps_link dut0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host       (host),
		.joy_raw    (joy_raw),
		.status_in  (status_in),
		.status_set (status_set),
		.ioctl_wait (ioctl_wait),
		.host_dout  (host_dout),
		.host_wait  (host_wait),
		.joysticks  (joysticks),
		.buttons    (buttons),
		.status     (status),
		.ioctl      (ioctl),
		.ps2_key    (ps2_key)
	);

	hps_link_checker check0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.joy_raw     (joy_raw),
		.status_in   (status_in),
		.status_set  (status_set),
		.host_dout   (host_dout),
		.host_wait   (host_wait),
		.ioctl_wait  (ioctl_wait),
		.joysticks   (joysticks),
		.buttons     (buttons),
		.status      (status),
		.ioctl       (ioctl),
		.ps2_key     (ps2_key),
		.test_id     (test_id),
		.test_done   (test_done),
		.run_done    (run_done),
		.error_count (error_count)
	);

	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	function automatic logic [15:0] rand_word();
		return 16'($urandom);
	endfunction

	function automatic logic [15:0] joy_cmd(input int kind);
		case (kind)
			0:       return `HPS_CMD_JOY0;
			1:       return `HPS_CMD_JOY1;
			2:       return `HPS_CMD_JOY2;
			3:       return `HPS_CMD_JOY3;
			default: return `HPS_CMD_CFG;
		endcase
	endfunction

	// one strobe that is held back while the DUT asks the host to wait
	task automatic send_word(input logic [15:0] data);
		int waited;
		waited = 0;
		while (host_wait && waited < 200) begin
			@(posedge clk_sys);
			waited++;
		end
		if (host_wait) begin
			$display("timeout: host_wait stayed high for 200 cycles");
			$display("Testbench failed");
			$finish;
		end else begin
			host.strobe <= 1'b1;
			host.din    <= data;
			tick(1);
			host.strobe <= 1'b0;
			tick(3);
		end
	endtask

	task automatic send_frame(input logic [15:0] cmd);
		host.enable <= 1'b1;
		tick(1);
		send_word(cmd);
		foreach (args[i])
			send_word(args[i]);
		args.delete();
		host.enable <= 1'b0;
		tick(4);
	endtask

	task automatic end_test;
		test_done <= 1'b1;
		tick(1);
		test_done <= 1'b0;
		tick(1);
	endtask

	initial begin
		int          n;
		int          kind;
		int          b;
		logic [7:0]  code;
		logic [31:0] seq;

		void'($urandom(27223));
		reset       = 1'b1;
		host        = '0;
		joy_raw     = 16'h0000;
		status_in   = 64'd0;
		status_set  = 1'b0;
		wait_random = 1'b0;
		test_id     = 4'd0;
		test_done   = 1'b0;
		run_done    = 1'b0;
		tick(3);
		reset <= 1'b0;
		tick(2);

		//////////////////////////////////////////////////
		test_id <= 4'd1;
		repeat (12) begin
			kind = $urandom % 5;
			n = (kind == 4) ? 1 : 1 + $urandom % 3;
			repeat (n) args.push_back(rand_word());
			send_frame(joy_cmd(kind));
		end
		end_test();

		test_id <= 4'd2;
		repeat (4) begin
			repeat (4) args.push_back(rand_word());
			send_frame(`HPS_CMD_STATUS);
		end
		end_test();

		test_id <= 4'd3;
		repeat (6) begin
			n = 1 + $urandom % 4;
			repeat (n) begin
				status_in  <= {rand_word(), rand_word(), rand_word(), rand_word()};
				status_set <= 1'b1;
				tick(1);
				status_set <= 1'b0;
				tick(1 + $urandom % 3);
			end
			repeat (4) args.push_back(rand_word());
			send_frame(`HPS_CMD_STATUS_REQ);
			joy_raw <= rand_word();
			tick(1);
			repeat (2) args.push_back(16'h0000);
			send_frame(`HPS_CMD_JOY_RAW);
		end
		end_test();

		//////////////////////////////////////////////////
		test_id     <= 4'd4;
		wait_random <= 1'b1;
		repeat (3) begin
			args.push_back({8'h00, 8'($urandom)});
			send_frame(`HPS_CMD_FILE_INDEX);
			args.push_back(rand_word());
			args.push_back(rand_word());
			send_frame(`HPS_CMD_FILE_INFO);
			args.push_back({8'h00, 8'(1 + $urandom % 255)});
			send_frame(`HPS_CMD_FILE_TX);
			repeat (1 + $urandom % 3) begin
				repeat (1 + $urandom % 6) args.push_back(rand_word());
				send_frame(`HPS_CMD_FILE_DAT);
			end
			args.push_back(16'h0000);
			send_frame(`HPS_CMD_FILE_TX);
		end
		wait_random <= 1'b0;
		end_test();

		test_id <= 4'd5;
		repeat (24) begin
			kind = $urandom % 6;
			code = 8'($urandom % 128);
			case (kind)
				0: args.push_back({8'h00, code});
				1: begin
					args.push_back(16'h00f0);
					args.push_back({8'h00, code});
				end
				2: begin
					args.push_back(16'h00e0);
					args.push_back({8'h00, code});
				end
				3: begin
					args.push_back(16'h00e0);
					args.push_back(16'h00f0);
					args.push_back({8'h00, code});
				end
				4: begin
					n = $urandom % 3;
					seq = (n == 0) ? 32'he012e07c : (n == 1) ? 32'h7ce0f012 : 32'hf014f077;
					for (b = 3; b >= 0; b--)
						args.push_back({8'h00, seq[8*b +: 8]});
				end
				default: begin
					args.push_back({8'h00, code});
					args.push_back({`HPS_SKIP_MARK, code});
					args.push_back(16'h0055);
				end
			endcase
			send_frame(`HPS_CMD_KBD);
		end
		end_test();

		run_done <= 1'b1;
		tick(1);
		run_done <= 1'b0;
		tick(2);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hps_link.f
+incdir+logic
logic/hps_link_pkg.sv
logic/frame_decoder.sv
logic/io_registers.sv
logic/file_loader.sv
logic/keyboard_decoder.sv
logic/hps_link.sv
tests/hps_link_checker.sv
tests/hps_link_assert.sv
tests/hps_link_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := hps_link_tb
FILELIST  := hps_link.f
BUILD     := obj_dir
PASS_MSG  := Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
